// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --assert -j 0
TOP       = tb_conv_top
FILELIST  = build.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^test passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== build.f ====
hw/conv_pkg.sv
hw/conv_seq.sv
hw/kernel_weight_reg.sv
hw/pixel_window.sv
hw/conv_mac.sv
hw/conv_top.sv
verification/tb_conv_top.sv

// ==== hw/conv_mac.sv ====
`timescale 1ns/10ps
`default_nettype none

module conv_mac (
        input  wire                sclk,
        input  wire                s_rst_n,
        input  wire                win_vld,
        input  wire [conv_pkg::kernel_size*conv_pkg::kernel_size-1:0] window,
        input  wire conv_pkg::weight_t [conv_pkg::kernel_size*conv_pkg::kernel_size-1:0] weights,
        input  wire conv_pkg::bias_t   bias,
        output conv_pkg::rslt_t    conv_rslt_act,
        output logic               conv_rslt_act_vld
);

conv_pkg::rslt_t [conv_pkg::kernel_size-1:0] row_sum_nxt;
conv_pkg::rslt_t [conv_pkg::kernel_size-1:0] row_sum;
conv_pkg::bias_t                             bias_d;
conv_pkg::rslt_t                             total;
logic                                        vld_d;

// *************************************************************************
// stage 1 gates each weight by its pixel and forms one partial sum per row
// *************************************************************************
always_comb begin
        for (int r = 0; r < conv_pkg::kernel_size; r++) begin
                row_sum_nxt[r] = '0;
                for (int c = 0; c < conv_pkg::kernel_size; c++) begin
                        if (window[r*conv_pkg::kernel_size+c]) begin   // pixel gates its weight
                                row_sum_nxt[r] = row_sum_nxt[r] +
                                        conv_pkg::rslt_t'(weights[r*conv_pkg::kernel_size+c]);
                        end
                end
        end
end

always_ff @(posedge sclk) begin
        if (win_vld) begin
                row_sum <= row_sum_nxt;
                bias_d  <= bias;
        end
end

// *************************************************************************
// stage 2 adds the row sums and the bias and rectifies the total
// *************************************************************************
always_comb begin
        total = conv_pkg::rslt_t'(bias_d);
        for (int r = 0; r < conv_pkg::kernel_size; r++) begin
                total = total + row_sum[r];
        end
end

always_ff @(posedge sclk) begin
        if (vld_d) begin
                conv_rslt_act <= total[conv_pkg::rslt_width-1] ? '0 : total;   // clamp negatives
        end
end

always_ff @(posedge sclk or negedge s_rst_n) begin
        if (!s_rst_n) begin
                vld_d             <= 1'b0;
                conv_rslt_act_vld <= 1'b0;
        end else begin
                vld_d             <= win_vld;
                conv_rslt_act_vld <= vld_d;
        end
end

a_rslt_nonneg : assert property (@(posedge sclk) disable iff (!s_rst_n)
        conv_rslt_act_vld |-> !conv_rslt_act[conv_pkg::rslt_width-1]);

endmodule

`default_nettype wire

// ==== hw/conv_pkg.sv ====
`default_nettype none

package conv_pkg;

// *************************************************************************
// image and kernel geometry
// *************************************************************************
localparam int kernel_size      = 5;
localparam int image_size       = 28;
localparam int line_reads       = 32;                            // 28 pixels + 4 padding reads
localparam int out_size         = image_size - kernel_size + 1;  // 24
localparam int kernel_count     = 30;

// *************************************************************************
// data and address widths
// *************************************************************************
localparam int weight_width     = 16;
localparam int bias_width       = 16;
localparam int rslt_width       = 32;
localparam int col_addr_width   = 5;
localparam int row_width        = 5;
localparam int param_addr_width = 8;                             // kernel_count * kernel_size < 256
localparam int kernel_cnt_width = $clog2(kernel_count);

typedef logic signed [weight_width-1:0] weight_t;
typedef logic signed [bias_width-1:0]   bias_t;
typedef logic signed [rslt_width-1:0]   rslt_t;                  // sum before the rectifier
typedef logic        [kernel_size-1:0]  pix_col_t;               // bit i is row offset i

// sequencer states
typedef enum logic {
        st_idle,
        st_run
} seq_state_e;

endpackage

`default_nettype wire

// ==== hw/conv_seq.sv ====
`timescale 1ns/10ps
`default_nettype none

module conv_seq (
        input  wire                                   sclk,
        input  wire                                   s_rst_n,
        input  wire                                   cal_start,
        output logic [conv_pkg::col_addr_width-1:0]   col_addr,
        output logic [conv_pkg::row_width-1:0]        row_sel,
        output logic [conv_pkg::param_addr_width-1:0] param_rd_addr,
        output logic                                  weight_load,
        output logic                                  win_vld,
        output logic                                  conv_busy
);

conv_pkg::seq_state_e                  state;
logic [conv_pkg::kernel_cnt_width-1:0] kernel_cnt;
logic                                  running;
logic                                  line_end;
logic                                  kernel_end;
logic                                  run_end;

assign running    = (state == conv_pkg::st_run);
assign line_end   = running && (col_addr == conv_pkg::col_addr_width'(conv_pkg::line_reads - 1));
assign kernel_end = line_end && (row_sel == conv_pkg::row_width'(conv_pkg::out_size - 1));
assign run_end    = kernel_end &&
                    (kernel_cnt == conv_pkg::kernel_cnt_width'(conv_pkg::kernel_count - 1));
assign conv_busy  = running;

// *************************************************************************
// run control and counters
// *************************************************************************
always_ff @(posedge sclk or negedge s_rst_n) begin
        if (!s_rst_n) begin
                state <= conv_pkg::st_idle;
        end else if (run_end) begin
                state <= conv_pkg::st_idle;
        end else if (cal_start && !running) begin              // pulses while running are ignored
                state <= conv_pkg::st_run;
        end
end

always_ff @(posedge sclk or negedge s_rst_n) begin
        if (!s_rst_n) begin
                col_addr   <= '0;
                row_sel    <= '0;
                kernel_cnt <= '0;
        end else if (running) begin
                col_addr <= line_end ? '0 : col_addr + 1'b1;
                if (kernel_end) begin
                        row_sel <= '0;
                end else if (line_end) begin
                        row_sel <= row_sel + 1'b1;
                end
                if (run_end) begin
                        kernel_cnt <= '0;
                end else if (kernel_end) begin
                        kernel_cnt <= kernel_cnt + 1'b1;
                end
        end
end

// weight address walks kernel*5 .. kernel*5+4 on row 0, then waits for the next kernel
always_ff @(posedge sclk or negedge s_rst_n) begin
        if (!s_rst_n) begin
                param_rd_addr <= '0;
        end else if (!running || run_end) begin
                param_rd_addr <= '0;
        end else if (kernel_end) begin
                param_rd_addr <= param_rd_addr + 1'b1;
        end else if (row_sel == '0 &&
                     col_addr < conv_pkg::col_addr_width'(conv_pkg::kernel_size - 1)) begin
                param_rd_addr <= param_rd_addr + 1'b1;
        end
end

// *************************************************************************
// strobes
// *************************************************************************
always_ff @(posedge sclk or negedge s_rst_n) begin
        if (!s_rst_n) begin
                weight_load <= 1'b0;
                win_vld     <= 1'b0;
        end else begin
                weight_load <= running && (row_sel == '0) &&    // high for col_addr 1..5
                               (col_addr <= conv_pkg::col_addr_width'(conv_pkg::kernel_size - 1));
                // column x+4 arrives at col_addr x+5, the window is full one cycle later
                win_vld     <= running &&
                               (col_addr >= conv_pkg::col_addr_width'(conv_pkg::kernel_size)) &&
                               (col_addr <= conv_pkg::col_addr_width'(conv_pkg::image_size));
        end
end

a_col_range : assert property (@(posedge sclk) disable iff (!s_rst_n)
        col_addr <= conv_pkg::col_addr_width'(conv_pkg::line_reads - 1));
a_param_range : assert property (@(posedge sclk) disable iff (!s_rst_n)
        param_rd_addr < conv_pkg::param_addr_width'(conv_pkg::kernel_count * conv_pkg::kernel_size));
a_load_in_run : assert property (@(posedge sclk) disable iff (!s_rst_n)
        weight_load |-> running);

endmodule

`default_nettype wire

// ==== hw/conv_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module conv_top (
        input  wire                                   sclk,
        input  wire                                   s_rst_n,
        input  wire                                   cal_start,
        // pixel memory
        output logic [conv_pkg::col_addr_width-1:0]   col_addr,
        output logic [conv_pkg::row_width-1:0]        row_sel,
        input  wire conv_pkg::pix_col_t               col_data,
        // parameter memory
        output logic [conv_pkg::param_addr_width-1:0] param_rd_addr,
        input  wire conv_pkg::weight_t                w_h0,
        input  wire conv_pkg::weight_t                w_h1,
        input  wire conv_pkg::weight_t                w_h2,
        input  wire conv_pkg::weight_t                w_h3,
        input  wire conv_pkg::weight_t                w_h4,
        input  wire conv_pkg::bias_t                  param_bias,
        // results
        output logic                                  conv_busy,
        output conv_pkg::rslt_t                       conv_rslt_act,
        output logic                                  conv_rslt_act_vld
);

logic                                                                       weight_load;
logic                                                                       win_vld;
logic [conv_pkg::kernel_size*conv_pkg::kernel_size-1:0]                     window;
conv_pkg::weight_t [conv_pkg::kernel_size*conv_pkg::kernel_size-1:0]        weights;
conv_pkg::bias_t                                                            bias;

conv_seq conv_seq_inst (
        .sclk           (sclk),
        .s_rst_n        (s_rst_n),
        .cal_start      (cal_start),
        .col_addr       (col_addr),
        .row_sel        (row_sel),
        .param_rd_addr  (param_rd_addr),
        .weight_load    (weight_load),
        .win_vld        (win_vld),
        .conv_busy      (conv_busy)
);

kernel_weight_reg kernel_weight_reg_inst (
        .sclk           (sclk),
        .s_rst_n        (s_rst_n),
        .weight_load    (weight_load),
        .w_h0           (w_h0),
        .w_h1           (w_h1),
        .w_h2           (w_h2),
        .w_h3           (w_h3),
        .w_h4           (w_h4),
        .param_bias     (param_bias),
        .weights        (weights),
        .bias           (bias)
);

pixel_window pixel_window_inst (
        .sclk           (sclk),
        .s_rst_n        (s_rst_n),
        .col_data       (col_data),
        .window         (window)
);

conv_mac conv_mac_inst (
        .sclk              (sclk),
        .s_rst_n           (s_rst_n),
        .win_vld           (win_vld),
        .window            (window),
        .weights           (weights),
        .bias              (bias),
        .conv_rslt_act     (conv_rslt_act),
        .conv_rslt_act_vld (conv_rslt_act_vld)
);

endmodule

`default_nettype wire

// ==== hw/kernel_weight_reg.sv ====
`timescale 1ns/10ps
`default_nettype none

module kernel_weight_reg (
        input  wire                sclk,
        input  wire                s_rst_n,
        input  wire                weight_load,
        input  wire conv_pkg::weight_t w_h0,
        input  wire conv_pkg::weight_t w_h1,
        input  wire conv_pkg::weight_t w_h2,
        input  wire conv_pkg::weight_t w_h3,
        input  wire conv_pkg::weight_t w_h4,
        input  wire conv_pkg::bias_t   param_bias,
        output conv_pkg::weight_t [conv_pkg::kernel_size*conv_pkg::kernel_size-1:0] weights,
        output conv_pkg::bias_t    bias
);

conv_pkg::weight_t [conv_pkg::kernel_size-1:0] w_col;    // w_col[i] is kernel row i

assign w_col = {w_h4, w_h3, w_h2, w_h1, w_h0};

// *************************************************************************
// one shift chain per kernel row, weights[r*5+c] is row r column c;
// new columns enter at position 4 so the first column read ends at 0
// *************************************************************************
always_ff @(posedge sclk or negedge s_rst_n) begin
        if (!s_rst_n) begin
                weights <= '0;
                bias    <= '0;
        end else if (weight_load) begin
                for (int r = 0; r < conv_pkg::kernel_size; r++) begin
                        for (int c = 0; c < conv_pkg::kernel_size - 1; c++) begin
                                weights[r*conv_pkg::kernel_size+c] <=
                                        weights[r*conv_pkg::kernel_size+c+1];
                        end
                        weights[r*conv_pkg::kernel_size+conv_pkg::kernel_size-1] <= w_col[r];
                end
                bias <= param_bias;                              // same value on all five reads
        end
end

endmodule

`default_nettype wire

// ==== hw/pixel_window.sv ====
`timescale 1ns/10ps
`default_nettype none

module pixel_window (
        input  wire                 sclk,
        input  wire                 s_rst_n,
        input  wire conv_pkg::pix_col_t col_data,
        output logic [conv_pkg::kernel_size*conv_pkg::kernel_size-1:0] window
);

conv_pkg::pix_col_t [conv_pkg::kernel_size-1:0] cols;    // cols[0] is the oldest column

always_ff @(posedge sclk or negedge s_rst_n) begin
        if (!s_rst_n) begin
                cols <= '0;
        end else begin
                cols <= {col_data, cols[conv_pkg::kernel_size-1:1]};
        end
end

// same r*5+c ordering as the weight registers
always_comb begin
        for (int r = 0; r < conv_pkg::kernel_size; r++) begin
                for (int c = 0; c < conv_pkg::kernel_size; c++) begin
                        window[r*conv_pkg::kernel_size+c] = cols[c][r];
                end
        end
end

endmodule

`default_nettype wire

// ==== verification/tb_conv_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_conv_top;

localparam int ksize      = conv_pkg::kernel_size;
localparam int isize      = conv_pkg::image_size;
localparam int osize      = conv_pkg::out_size;
localparam int kcount     = conv_pkg::kernel_count;
localparam int run_cycles = kcount * osize * conv_pkg::line_reads;    // 23040 cycles per run
localparam int run_rslts  = kcount * osize * osize;                   // 17280 results per run

typedef enum {img_zero, img_ones, img_checker, img_random} img_pat_e;
typedef enum {wgt_random, wgt_fixed} wgt_pat_e;
typedef enum {bias_random, bias_large_neg, bias_zero} bias_mode_e;

logic                                  sclk;
logic                                  s_rst_n;
logic                                  cal_start;
logic [conv_pkg::col_addr_width-1:0]   col_addr;
logic [conv_pkg::row_width-1:0]        row_sel;
logic [conv_pkg::param_addr_width-1:0] param_rd_addr;
conv_pkg::pix_col_t                    col_data = '0;
conv_pkg::weight_t                     w_col [ksize] = '{default: '0};    // w_col[i] drives w_hi
conv_pkg::bias_t                       param_bias = '0;
logic                                  conv_busy;
conv_pkg::rslt_t                       conv_rslt_act;
logic                                  conv_rslt_act_vld;

logic                                  pix_mem [isize][isize];            // [row][column]
conv_pkg::weight_t                     w_mem [kcount*ksize][ksize];       // [address][kernel row]
conv_pkg::bias_t                       bias_mem [kcount];
logic [conv_pkg::col_addr_width-1:0]   col_q = '0;
logic [conv_pkg::row_width-1:0]        row_q = '0;
logic [conv_pkg::param_addr_width-1:0] par_q = '0;

string                                 name_q [$];
img_pat_e                              img_q [$];
wgt_pat_e                              wgt_q [$];
bias_mode_e                            bias_q [$];
bit                                    restart_q [$];
conv_pkg::rslt_t                       exp_q [$];
int                                    runs_total = 0;

initial begin
        sclk = 1'b0;
        forever #5 sclk = ~sclk;
end

conv_top conv_top_inst (
        .sclk              (sclk),
        .s_rst_n           (s_rst_n),
        .cal_start         (cal_start),
        .col_addr          (col_addr),
        .row_sel           (row_sel),
        .col_data          (col_data),
        .param_rd_addr     (param_rd_addr),
        .w_h0              (w_col[0]),
        .w_h1              (w_col[1]),
        .w_h2              (w_col[2]),
        .w_h3              (w_col[3]),
        .w_h4              (w_col[4]),
        .param_bias        (param_bias),
        .conv_busy         (conv_busy),
        .conv_rslt_act     (conv_rslt_act),
        .conv_rslt_act_vld (conv_rslt_act_vld)
);

// ***************************************************************************
// memory models answer one cycle after the address
// ***************************************************************************
function automatic conv_pkg::pix_col_t column_at(int row, int col);
        conv_pkg::pix_col_t data;
        data = '0;
        if (col < isize) begin                                  // padding reads return zero
                for (int i = 0; i < ksize; i++) begin
                        if (row + i < isize) begin
                                data[i] = pix_mem[row+i][col];
                        end
                end
        end
        return data;
endfunction

always @(negedge sclk) begin
        col_data <= column_at(int'(row_q), int'(col_q));
        for (int i = 0; i < ksize; i++) begin
                w_col[i] <= w_mem[par_q][i];
        end
        param_bias <= bias_mem[int'(par_q) / ksize];
        col_q      <= col_addr;
        row_q      <= row_sel;
        par_q      <= param_rd_addr;
end

// ***************************************************************************
// test table, stimulus and reference model
// ***************************************************************************
task automatic add_entry(input string name, input img_pat_e ip, input wgt_pat_e wp,
                         input bias_mode_e bm, input bit restart);
        name_q.push_back(name);
        img_q.push_back(ip);
        wgt_q.push_back(wp);
        bias_q.push_back(bm);
        restart_q.push_back(restart);
        runs_total += restart ? 2 : 1;                          // restart entries run twice
endtask

task automatic fill_memories(input img_pat_e ip, input wgt_pat_e wp, input bias_mode_e bm);
        for (int r = 0; r < isize; r++) begin
                for (int c = 0; c < isize; c++) begin
                        case (ip)
                                img_zero:    pix_mem[r][c] = 1'b0;
                                img_ones:    pix_mem[r][c] = 1'b1;
                                img_checker: pix_mem[r][c] = 1'((r + c) % 2);
                                default:     pix_mem[r][c] = 1'($urandom % 2);
                        endcase
                end
        end
        for (int k = 0; k < kcount; k++) begin
                for (int a = 0; a < ksize * ksize; a++) begin      // a = row*5 + column
                        if (wp == wgt_fixed) begin
                                w_mem[k*ksize+a%ksize][a/ksize] =
                                        conv_pkg::weight_t'((k * 25 + a) * 37 - 2000);
                        end else begin
                                w_mem[k*ksize+a%ksize][a/ksize] = conv_pkg::weight_t'($urandom);
                        end
                end
                case (bm)
                        bias_random:    bias_mem[k] = conv_pkg::bias_t'($urandom);
                        bias_large_neg: bias_mem[k] =
                                conv_pkg::bias_t'(-20000 - int'($urandom % 12000));
                        default:        bias_mem[k] = '0;
                endcase
        end
endtask

// clamped sum of the bias and every weight whose pixel is set
function automatic conv_pkg::rslt_t model_result(int k, int y, int x);
        int acc;
        acc = int'(bias_mem[k]);
        for (int r = 0; r < ksize; r++) begin
                for (int c = 0; c < ksize; c++) begin
                        if (pix_mem[y+r][x+c]) begin
                                acc += int'(w_mem[k*ksize+c][r]);
                        end
                end
        end
        return conv_pkg::rslt_t'((acc < 0) ? 0 : acc);
endfunction

// ***************************************************************************
// checks
// ***************************************************************************
task automatic abort_run();
        $display("test failed");
        $fatal(1, "stopped at the first error");
endtask

task automatic check_rslt(input string name, input int idx, input conv_pkg::rslt_t expected,
                          input conv_pkg::rslt_t actual);
        if (actual !== expected) begin
                $display("ERR %s k%0d y%0d x%0d: expected %0d, actual %0d", name,
                         idx / (osize * osize), (idx / osize) % osize, idx % osize,
                         expected, actual);
                abort_run();
        end
endtask

task automatic check_count(input string name, input string what, input int expected,
                           input int actual);
        if (actual !== expected) begin
                $display("ERR %s %s: expected %0d, actual %0d", name, what, expected, actual);
                abort_run();
        end
endtask

task automatic check_level(input string name, input string what, input logic expected,
                           input logic actual);
        if (actual !== expected) begin
                $display("ERR %s %s: expected %b, actual %b", name, what, expected, actual);
                abort_run();
        end
endtask

task automatic take_result(input string name, inout int n);
        if (conv_rslt_act_vld === 1'b1) begin
                if (n >= exp_q.size()) begin
                        $display("%s: the DUT gave more results than one run holds", name);
                        abort_run();
                end else begin
                        check_rslt(name, n, exp_q[n], conv_rslt_act);
                        n++;
                end
        end
endtask

// starts and returns on a falling edge
task automatic run_and_check(input string name, input bit restart);
        int n;
        int cycle;
        n     = 0;
        cycle = 0;
        cal_start = 1'b1;
        @(negedge sclk);
        cal_start = 1'b0;
        check_level(name, "conv_busy after cal_start", 1'b1, conv_busy);
        while (conv_busy === 1'b1) begin
                take_result(name, n);
                cal_start = restart && (cycle == run_cycles / 2);  // must be ignored
                cycle++;
                @(negedge sclk);
        end
        check_count(name, "busy cycles", run_cycles, cycle);
        repeat (8) begin                                        // nothing may trail the run
                take_result(name, n);
                @(negedge sclk);
        end
        check_count(name, "result count", run_rslts, n);
        check_level(name, "conv_busy after run", 1'b0, conv_busy);
endtask

initial begin
        void'($urandom(82613));
        s_rst_n   = 1'b0;
        cal_start = 1'b0;
        add_entry("zero_image", img_zero, wgt_random, bias_random, 1'b0);
        add_entry("ones_image", img_ones, wgt_random, bias_random, 1'b0);
        add_entry("checker_neg_bias", img_checker, wgt_random, bias_large_neg, 1'b0);
        add_entry("random_image", img_random, wgt_random, bias_random, 1'b0);
        add_entry("random_neg_bias", img_random, wgt_random, bias_large_neg, 1'b0);
        add_entry("restart_ignored", img_checker, wgt_fixed, bias_zero, 1'b1);
        repeat (4) @(negedge sclk);
        s_rst_n = 1'b1;
        repeat (4) begin
                @(negedge sclk);
                check_level("after_reset", "conv_busy", 1'b0, conv_busy);
                check_level("after_reset", "conv_rslt_act_vld", 1'b0, conv_rslt_act_vld);
        end
        for (int t = 0; t < name_q.size(); t++) begin
                fill_memories(img_q[t], wgt_q[t], bias_q[t]);
                exp_q.delete();
                for (int k = 0; k < kcount; k++) begin           // kernel, row, column order
                        for (int y = 0; y < osize; y++) begin
                                for (int x = 0; x < osize; x++) begin
                                        exp_q.push_back(model_result(k, y, x));
                                end
                        end
                end
                run_and_check(name_q[t], restart_q[t]);
                if (restart_q[t]) begin
                        run_and_check({name_q[t], "_rerun"}, 1'b0);
                end
        end
        $display("test passed");
        $finish;
end

// watchdog allows every run's length plus 20 percent
initial begin
        longint limit_ns;
        @(posedge s_rst_n);
        limit_ns = longint'(runs_total) * run_cycles * 10;
        limit_ns = limit_ns + limit_ns / 5;
        #(limit_ns);
        $display("timeout: the runs did not finish within %0d ns", limit_ns);
        abort_run();
end

endmodule

`default_nettype wire
